// File: all.f
+incdir+include
source/m1_pkg.sv
source/m1_pair_if.sv
source/m1_rgb_if.sv
source/m1_chroma_filter.sv
source/m1_fetch_decode.sv
source/m1_color_convert.sv
source/m1_rgb_writer.sv
source/m1.sv
tests/m1_sram_model.sv
tests/tb_m1.sv

// File: include/m1_consts.svh
`ifndef M1_CONSTS_SVH
`define M1_CONSTS_SVH

// Word addresses in the external SRAM
`define M1_Y_OFFSET       18'd0        // Y plane, full resolution
`define M1_U_OFFSET       18'd38400    // U plane, half width
`define M1_V_OFFSET       18'd57600    // V plane, half width
`define M1_RGB_OFFSET     18'd146944   // Packed RGB output

`define M1_PAIRS_PER_ROW  160          // Also chroma samples per row
`define M1_ROWS           240
`define M1_TOTAL_WRITES   115200       // Three words per pixel pair

`define M1_FRAME_CYCLES   6            // Slots 0-2 read, 3-5 write
`define M1_READ_LATENCY   2            // Address to data

// Six-tap interpolation, symmetric
`define M1_TAP_0          32'sd21      // Outer pair
`define M1_TAP_1          32'sd52      // Middle pair, subtracted
`define M1_TAP_2          32'sd159     // Inner pair

// YUV to RGB, 16 fractional bits
`define M1_CSC_Y          32'sd76284
`define M1_CSC_RV         32'sd104595
`define M1_CSC_GU         32'sd25624
`define M1_CSC_GV         32'sd53281
`define M1_CSC_BU         32'sd132251
`define M1_Y_BIAS         32'sd16
`define M1_C_BIAS         32'sd128     // Chroma offset and filter rounding

`endif

// File: source/m1.sv
module m1 (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic m1_start,
	input m1_pkg::sram_word_t SRAM_read_data,
	output m1_pkg::sram_addr_t SRAM_address,
	output m1_pkg::sram_word_t SRAM_write_data,
	output logic SRAM_we_n,
	output logic m1_end
);

	m1_pkg::sram_addr_t rd_addr;
	logic wr_slot;
	logic done_reads;

	m1_pair_if pair_bus ();         // Fetch to execute
	m1_rgb_if rgb_bus ();           // Execute to writer

	m1_fetch_decode fetch (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.m1_start(m1_start),
		.SRAM_read_data(SRAM_read_data),
		.rd_addr(rd_addr),
		.wr_slot(wr_slot),
		.done_reads(done_reads),
		.pair(pair_bus.src)
	);

	m1_color_convert execute (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.pair(pair_bus.dst),
		.rgb(rgb_bus.src)
	);

	m1_rgb_writer writer (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.wr_slot(wr_slot),
		.done_reads(done_reads),
		.rd_addr(rd_addr),
		.rgb(rgb_bus.dst),
		.SRAM_address(SRAM_address),
		.SRAM_write_data(SRAM_write_data),
		.SRAM_we_n(SRAM_we_n),
		.m1_end(m1_end)
	);

endmodule

// File: source/m1_chroma_filter.sv
`include "m1_consts.svh"

module m1_chroma_filter (
	input logic CLOCK_50_I,
	input logic resetn,
	input m1_pkg::chroma_taps_t taps,
	output m1_pkg::pixel_t odd_sample
);

	logic [8:0] sum_outer;          // c[k-2] + c[k+3]
	logic [8:0] sum_mid;            // c[k-1] + c[k+2]
	logic [8:0] sum_inner;          // c[k] + c[k+1]
	m1_pkg::product_t acc;

	assign sum_outer = taps[0] + taps[5];
	assign sum_mid = taps[1] + taps[4];
	assign sum_inner = taps[2] + taps[3];

	// Rounded before the shift
	assign acc = `M1_TAP_0 * m1_pkg::product_t'(sum_outer)
		- `M1_TAP_1 * m1_pkg::product_t'(sum_mid)
		+ `M1_TAP_2 * m1_pkg::product_t'(sum_inner)
		+ `M1_C_BIAS;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn)
			odd_sample <= 8'd0;
		else
			odd_sample <= m1_pkg::clip_pixel(acc >>> 8);  // Negative lobes can undershoot
	end

endmodule

// File: source/m1_color_convert.sv
`include "m1_consts.svh"

module m1_color_convert (
	input logic CLOCK_50_I,
	input logic resetn,
	m1_pair_if.dst pair,
	m1_rgb_if.src rgb
);

	m1_pkg::pixel_t y_s1 [2];       // Index 0 even, 1 odd
	m1_pkg::pixel_t u_even_s1;
	m1_pkg::pixel_t v_even_s1;
	m1_pkg::pixel_t u_odd;
	m1_pkg::pixel_t v_odd;
	m1_pkg::pixel_t u_px [2];
	m1_pkg::pixel_t v_px [2];
	m1_pkg::product_t y_p [2];
	m1_pkg::product_t rv_p [2];
	m1_pkg::product_t gu_p [2];
	m1_pkg::product_t gv_p [2];
	m1_pkg::product_t bu_p [2];
	m1_pkg::pixel_t r_q [2];
	m1_pkg::pixel_t g_q [2];
	m1_pkg::pixel_t b_q [2];
	logic valid_s1;
	logic valid_s2;
	logic valid_s3;

	m1_chroma_filter u_filter (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.taps(pair.u_taps),
		.odd_sample(u_odd)
	);

	m1_chroma_filter v_filter (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.taps(pair.v_taps),
		.odd_sample(v_odd)
	);

	assign u_px[0] = u_even_s1;
	assign u_px[1] = u_odd;
	assign v_px[0] = v_even_s1;
	assign v_px[1] = v_odd;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
			valid_s3 <= 1'b0;
		end else begin
			valid_s1 <= pair.valid;
			valid_s2 <= valid_s1;
			valid_s3 <= valid_s2;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		y_s1[0] <= pair.y_even;       // In step with the filters
		y_s1[1] <= pair.y_odd;
		u_even_s1 <= pair.u_taps[2];  // c[k] directly
		v_even_s1 <= pair.v_taps[2];
		for (int i = 0; i < 2; i++) begin
			y_p[i] <= `M1_CSC_Y * (m1_pkg::product_t'(y_s1[i]) - `M1_Y_BIAS);
			rv_p[i] <= `M1_CSC_RV * (m1_pkg::product_t'(v_px[i]) - `M1_C_BIAS);
			gu_p[i] <= `M1_CSC_GU * (m1_pkg::product_t'(u_px[i]) - `M1_C_BIAS);
			gv_p[i] <= `M1_CSC_GV * (m1_pkg::product_t'(v_px[i]) - `M1_C_BIAS);
			bu_p[i] <= `M1_CSC_BU * (m1_pkg::product_t'(u_px[i]) - `M1_C_BIAS);
			r_q[i] <= m1_pkg::clip_pixel((y_p[i] + rv_p[i]) >>> 16);
			g_q[i] <= m1_pkg::clip_pixel((y_p[i] - gu_p[i] - gv_p[i]) >>> 16);
			b_q[i] <= m1_pkg::clip_pixel((y_p[i] + bu_p[i]) >>> 16);
		end
	end

	assign rgb.valid = valid_s3;
	assign rgb.r0 = r_q[0];
	assign rgb.g0 = g_q[0];
	assign rgb.b0 = b_q[0];
	assign rgb.r1 = r_q[1];
	assign rgb.g1 = g_q[1];
	assign rgb.b1 = b_q[1];

endmodule

// File: source/m1_fetch_decode.sv
`include "m1_consts.svh"

module m1_fetch_decode (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic m1_start,
	input m1_pkg::sram_word_t SRAM_read_data,
	output m1_pkg::sram_addr_t rd_addr,
	output logic wr_slot,
	output logic done_reads,
	m1_pair_if.src pair
);

	typedef enum logic [1:0] {S_IDLE, S_LEAD, S_PAIR, S_DRAIN} state_t;

	localparam logic [2:0] LAST_SLOT = 3'(`M1_FRAME_CYCLES - 1);
	localparam logic [2:0] RD0_DATA = 3'(`M1_READ_LATENCY);      // Read from slot 0 returns
	localparam logic [2:0] RD1_DATA = 3'(`M1_READ_LATENCY + 1);
	localparam logic [2:0] RD2_DATA = 3'(`M1_READ_LATENCY + 2);
	localparam logic [7:0] LAST_PAIR = 8'(`M1_PAIRS_PER_ROW - 1);
	localparam logic [7:0] TAIL_PAIR = 8'(`M1_PAIRS_PER_ROW - 4); // No new chroma from here
	localparam logic [7:0] LAST_ROW = 8'(`M1_ROWS - 1);

	state_t state;
	logic [2:0] slot;
	logic frame_cnt;                // Second lead-in or drain frame
	logic [7:0] pair_cnt;
	logic [7:0] row_cnt;
	m1_pkg::sram_addr_t y_addr;
	m1_pkg::sram_addr_t u_addr;
	m1_pkg::sram_addr_t v_addr;
	m1_pkg::sram_word_t u_buf;      // Latest chroma words of the row
	m1_pkg::sram_word_t v_buf;
	m1_pkg::pixel_t y_even;
	m1_pkg::pixel_t y_odd;
	m1_pkg::chroma_taps_t u_win;
	m1_pkg::chroma_taps_t v_win;
	m1_pkg::pixel_t u_next;
	m1_pkg::pixel_t v_next;
	logic frame_end;
	logic in_row;
	logic uv_read;

	assign frame_end = (slot == LAST_SLOT);
	assign in_row = (pair_cnt < TAIL_PAIR);
	assign uv_read = in_row && !pair_cnt[0];  // One U/V word feeds two pairs

	// Even pair takes the high byte, odd pair the low byte; past the edge repeat c159
	assign u_next = !in_row ? u_win[5] : (pair_cnt[0] ? u_buf[7:0] : u_buf[15:8]);
	assign v_next = !in_row ? v_win[5] : (pair_cnt[0] ? v_buf[7:0] : v_buf[15:8]);

	assign wr_slot = (state != S_IDLE) && (slot >= 3'd3);

	assign pair.valid = (state == S_PAIR) && frame_end;
	assign pair.y_even = y_even;
	assign pair.y_odd = y_odd;
	assign pair.u_taps = u_win;
	assign pair.v_taps = v_win;

	always_comb begin
		rd_addr = `M1_Y_OFFSET + y_addr;
		case (state)
			S_LEAD: begin
				if (slot == 3'd0)
					rd_addr = `M1_U_OFFSET + u_addr;
				else if (slot == 3'd1)
					rd_addr = `M1_V_OFFSET + v_addr;
			end
			S_PAIR: begin
				if (slot == 3'd1)
					rd_addr = `M1_U_OFFSET + u_addr;
				else if (slot == 3'd2)
					rd_addr = `M1_V_OFFSET + v_addr;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= S_IDLE;
			slot <= 3'd0;
			frame_cnt <= 1'b0;
			pair_cnt <= 8'd0;
			row_cnt <= 8'd0;
			y_addr <= '0;
			u_addr <= '0;
			v_addr <= '0;
			done_reads <= 1'b0;
		end else begin
			slot <= (state == S_IDLE || frame_end) ? 3'd0 : slot + 3'd1;
			case (state)
				S_IDLE: begin
					if (m1_start) begin
						state <= S_LEAD;
						frame_cnt <= 1'b0;
						pair_cnt <= 8'd0;
						row_cnt <= 8'd0;
						y_addr <= '0;
						u_addr <= '0;
						v_addr <= '0;
						done_reads <= 1'b0;
					end
				end
				S_LEAD: begin
					if (slot == 3'd0)
						u_addr <= u_addr + 18'd1;
					if (slot == 3'd1)
						v_addr <= v_addr + 18'd1;
					if (frame_end) begin
						frame_cnt <= ~frame_cnt;
						if (frame_cnt)
							state <= S_PAIR;
					end
				end
				S_PAIR: begin
					if (slot == 3'd0)
						y_addr <= y_addr + 18'd1;
					if (slot == 3'd1 && uv_read)
						u_addr <= u_addr + 18'd1;
					if (slot == 3'd2 && uv_read)
						v_addr <= v_addr + 18'd1;
					if (frame_end) begin
						pair_cnt <= pair_cnt + 8'd1;
						if (pair_cnt == LAST_PAIR) begin
							pair_cnt <= 8'd0;
							row_cnt <= row_cnt + 8'd1;
							if (row_cnt == LAST_ROW) begin
								state <= S_DRAIN;
								done_reads <= 1'b1;  // Last pair just emitted
							end else begin
								state <= S_LEAD;
							end
						end
					end
				end
				S_DRAIN: begin
					if (frame_end) begin   // Keeps write slots running
						frame_cnt <= ~frame_cnt;
						if (frame_cnt)
							state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (state == S_LEAD) begin
			if (slot == RD0_DATA) begin
				if (!frame_cnt) begin   // c0 replicated to the left
					u_win[0] <= SRAM_read_data[15:8];
					u_win[1] <= SRAM_read_data[15:8];
					u_win[2] <= SRAM_read_data[15:8];
					u_win[3] <= SRAM_read_data[7:0];
				end else begin
					u_win[4] <= SRAM_read_data[15:8];
					u_win[5] <= SRAM_read_data[7:0];
				end
			end
			if (slot == RD1_DATA) begin
				if (!frame_cnt) begin
					v_win[0] <= SRAM_read_data[15:8];
					v_win[1] <= SRAM_read_data[15:8];
					v_win[2] <= SRAM_read_data[15:8];
					v_win[3] <= SRAM_read_data[7:0];
				end else begin
					v_win[4] <= SRAM_read_data[15:8];
					v_win[5] <= SRAM_read_data[7:0];
				end
			end
		end
		if (state == S_PAIR) begin
			if (slot == RD0_DATA) begin
				y_even <= SRAM_read_data[15:8];
				y_odd <= SRAM_read_data[7:0];
			end
			if (slot == RD1_DATA && uv_read)
				u_buf <= SRAM_read_data;
			if (slot == RD2_DATA && uv_read)
				v_buf <= SRAM_read_data;
			if (frame_end) begin        // Advance to the next pair's window
				u_win <= {u_win[1:5], u_next};
				v_win <= {v_win[1:5], v_next};
			end
		end
	end

	// Both lead-in frames of a row stay free of pair strobes
	lead_in_quiet: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(state == S_LEAD && slot == 3'd0 && !frame_cnt) |-> !pair.valid [*2 * `M1_FRAME_CYCLES])
		else $error("Pair strobe during a lead-in frame");

endmodule

// File: source/m1_pair_if.sv
interface m1_pair_if;

	logic valid;                    // One cycle per pair
	m1_pkg::pixel_t y_even;
	m1_pkg::pixel_t y_odd;
	m1_pkg::chroma_taps_t u_taps;   // c[k-2] .. c[k+3], clamped
	m1_pkg::chroma_taps_t v_taps;

	modport src (
		output valid, y_even, y_odd, u_taps, v_taps
	);

	modport dst (
		input valid, y_even, y_odd, u_taps, v_taps
	);

endinterface

// File: source/m1_pkg.sv
package m1_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;

	// Index 0 is c[k-2], index 5 is c[k+3]
	typedef pixel_t [0:5] chroma_taps_t;

	typedef logic signed [31:0] product_t;

	// Saturate a shifted result to the 8-bit range
	function automatic pixel_t clip_pixel(input product_t value);
		if (value < 0)
			return 8'd0;
		else if (value > 255)
			return 8'd255;
		else
			return value[7:0];
	endfunction

endpackage

// File: source/m1_rgb_if.sv
interface m1_rgb_if;

	logic valid;                    // One cycle per pair
	m1_pkg::pixel_t r0;             // Even pixel
	m1_pkg::pixel_t g0;
	m1_pkg::pixel_t b0;
	m1_pkg::pixel_t r1;             // Odd pixel
	m1_pkg::pixel_t g1;
	m1_pkg::pixel_t b1;

	modport src (
		output valid, r0, g0, b0, r1, g1, b1
	);

	modport dst (
		input valid, r0, g0, b0, r1, g1, b1
	);

endinterface

// File: source/m1_rgb_writer.sv
`include "m1_consts.svh"

module m1_rgb_writer (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic wr_slot,
	input logic done_reads,
	input m1_pkg::sram_addr_t rd_addr,
	m1_rgb_if.dst rgb,
	output m1_pkg::sram_addr_t SRAM_address,
	output m1_pkg::sram_word_t SRAM_write_data,
	output logic SRAM_we_n,
	output logic m1_end
);

	m1_pkg::sram_word_t words [3];  // Head is the next word out
	logic [1:0] pending;
	m1_pkg::sram_addr_t wr_addr;
	logic wr_now;
	logic last_word;

	assign wr_now = wr_slot && (pending != 2'd0);
	assign last_word = wr_now && done_reads && (pending == 2'd1);  // Final word of the picture

	// Write slots take the bus only when a word is waiting
	assign SRAM_address = wr_now ? wr_addr : rd_addr;
	assign SRAM_write_data = words[0];
	assign SRAM_we_n = !wr_now;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			pending <= 2'd0;
			wr_addr <= `M1_RGB_OFFSET;
			m1_end <= 1'b0;
		end else begin
			if (rgb.valid)
				pending <= 2'd3;
			else if (wr_now)
				pending <= pending - 2'd1;
			if (wr_now)
				wr_addr <= last_word ? `M1_RGB_OFFSET : wr_addr + 18'd1;  // Rewind for next picture
			m1_end <= done_reads && (m1_end || last_word);  // Drops when a new picture starts
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (rgb.valid) begin
			words[0] <= {rgb.r0, rgb.g0};
			words[1] <= {rgb.b0, rgb.r1};
			words[2] <= {rgb.g1, rgb.b1};
		end else if (wr_now) begin
			words[0] <= words[1];
			words[1] <= words[2];
		end
	end

	wr_in_region: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!SRAM_we_n |-> (SRAM_address >= `M1_RGB_OFFSET)
			&& (SRAM_address <= `M1_RGB_OFFSET + `M1_TOTAL_WRITES - 1))
		else $error("Write outside the RGB region");

	// Three write slots always fit between pair strobes
	no_overrun: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		rgb.valid |-> pending == 2'd0)
		else $error("Pair strobe arrived with words still pending");

endmodule

// File: tests/m1_sram_model.sv
`include "m1_consts.svh"

module m1_sram_model (
	input logic CLOCK_50_I,
	input m1_pkg::sram_addr_t address,
	input m1_pkg::sram_word_t write_data,
	input logic we_n,
	output m1_pkg::sram_word_t read_data
);

	localparam int DEPTH = 1 << 18;  // Full 18-bit word space

	m1_pkg::sram_word_t mem [0:DEPTH-1];
	m1_pkg::sram_word_t read_pipe [`M1_READ_LATENCY];

	// Address registered on the edge, data out after the read latency
	always @(posedge CLOCK_50_I) begin
		read_pipe[0] <= mem[address];
		for (int i = 1; i < `M1_READ_LATENCY; i++)
			read_pipe[i] <= read_pipe[i-1];
		if (!we_n)
			mem[address] <= write_data;  // Write capture
	end

	assign read_data = read_pipe[`M1_READ_LATENCY - 1];

endmodule

// File: tests/tb_m1.sv
`include "m1_consts.svh"

module tb_m1;

	localparam int TIMEOUT_CYCLES = 300000;
	localparam int ROW_WORDS = `M1_PAIRS_PER_ROW / 2;    // Chroma words per row
	localparam int IMAGE_WORDS = int'(`M1_V_OFFSET) + `M1_ROWS * ROW_WORDS;

	logic CLOCK_50_I;
	logic resetn;
	logic m1_start;
	m1_pkg::sram_word_t SRAM_read_data;
	m1_pkg::sram_addr_t SRAM_address;
	m1_pkg::sram_word_t SRAM_write_data;
	logic SRAM_we_n;
	logic m1_end;

	logic [15:0] image [0:IMAGE_WORDS-1];  // Y, U and V planes as loaded
	int seed;
	int write_count = 0;
	int sat_high = 0;
	int sat_low = 0;
	int value_errors = 0;
	int other_errors = 0;
	logic started;

	m1 UUT (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.m1_start(m1_start),
		.SRAM_read_data(SRAM_read_data),
		.SRAM_address(SRAM_address),
		.SRAM_write_data(SRAM_write_data),
		.SRAM_we_n(SRAM_we_n),
		.m1_end(m1_end)
	);

	m1_sram_model sram (
		.CLOCK_50_I(CLOCK_50_I),
		.address(SRAM_address),
		.write_data(SRAM_write_data),
		.we_n(SRAM_we_n),
		.read_data(SRAM_read_data)
	);

	function automatic int saturate(int value);
		return (value < 0) ? 0 : ((value > 255) ? 255 : value);
	endfunction

	// Chroma sample j of a row, index clamped to the row
	function automatic int chroma_sample(int base, int row, int j);
		int idx;
		logic [15:0] word;
		idx = (j < 0) ? 0 : ((j > `M1_PAIRS_PER_ROW - 1) ? `M1_PAIRS_PER_ROW - 1 : j);
		word = image[base + row * ROW_WORDS + idx / 2];
		return (idx % 2 == 1) ? int'(word[7:0]) : int'(word[15:8]);
	endfunction

	function automatic int odd_chroma(int base, int row, int k);
		int acc;
		acc = `M1_TAP_0 * (chroma_sample(base, row, k - 2) + chroma_sample(base, row, k + 3))
			- `M1_TAP_1 * (chroma_sample(base, row, k - 1) + chroma_sample(base, row, k + 2))
			+ `M1_TAP_2 * (chroma_sample(base, row, k) + chroma_sample(base, row, k + 1))
			+ `M1_C_BIAS;
		return saturate(acc >>> 8);
	endfunction

	function automatic logic [23:0] rgb_of(int y, int u, int v);
		int yt;
		int r;
		int g;
		int b;
		yt = `M1_CSC_Y * (y - `M1_Y_BIAS);
		r = saturate((yt + `M1_CSC_RV * (v - `M1_C_BIAS)) >>> 16);
		g = saturate((yt - `M1_CSC_GU * (u - `M1_C_BIAS) - `M1_CSC_GV * (v - `M1_C_BIAS)) >>> 16);
		b = saturate((yt + `M1_CSC_BU * (u - `M1_C_BIAS)) >>> 16);
		return {r[7:0], g[7:0], b[7:0]};
	endfunction

	// Packed word w of the output, three per pixel pair
	function automatic logic [15:0] expected_word(int w);
		int n;
		int row;
		int k;
		int u_base;
		int v_base;
		logic [15:0] yw;
		logic [23:0] p0;
		logic [23:0] p1;
		n = w / 3;
		row = n / `M1_PAIRS_PER_ROW;
		k = n % `M1_PAIRS_PER_ROW;
		u_base = int'(`M1_U_OFFSET);
		v_base = int'(`M1_V_OFFSET);
		yw = image[int'(`M1_Y_OFFSET) + n];
		p0 = rgb_of(yw[15:8], chroma_sample(u_base, row, k), chroma_sample(v_base, row, k));
		p1 = rgb_of(yw[7:0], odd_chroma(u_base, row, k), odd_chroma(v_base, row, k));
		case (w % 3)
			0: return {p0[23:16], p0[15:8]};
			1: return {p0[7:0], p1[23:16]};
			default: return {p1[15:8], p1[7:0]};
		endcase
	endfunction

	// Bytes of word w that belong to the even pixel
	function automatic logic [15:0] even_mask(int w);
		case (w % 3)
			0: return 16'hffff;
			1: return 16'hff00;
			default: return 16'h0000;
		endcase
	endfunction

	task automatic load_image();
		for (int i = 0; i < IMAGE_WORDS; i++)
			image[i] = $random(seed);
		for (int k = 0; k < `M1_PAIRS_PER_ROW; k++)
			image[int'(`M1_Y_OFFSET) + k] = k[0] ? 16'h0000 : 16'hffff;  // Bright and dark pairs
		for (int j = 0; j < ROW_WORDS; j++) begin
			image[int'(`M1_U_OFFSET) + j] = (j < ROW_WORDS / 2) ? 16'hffff : 16'h0000;
			image[int'(`M1_V_OFFSET) + j] = (j < ROW_WORDS / 2) ? 16'hffff : 16'h0000;
		end
		for (int i = 0; i < IMAGE_WORDS; i++)
			sram.mem[i] = image[i];
	endtask

	initial begin
		CLOCK_50_I = 1'b0;
		forever #2 CLOCK_50_I = ~CLOCK_50_I;
	end

	always @(posedge CLOCK_50_I) begin
		if (resetn && !SRAM_we_n) begin
			write_count <= write_count + 1;
			if (write_count < 3 * `M1_PAIRS_PER_ROW) begin  // Row 0 extremes
				if (SRAM_write_data[15:8] == 8'hff || SRAM_write_data[7:0] == 8'hff)
					sat_high <= sat_high + 1;
				if (SRAM_write_data[15:8] == 8'h00 || SRAM_write_data[7:0] == 8'h00)
					sat_low <= sat_low + 1;
			end
		end
	end

	quiet_before_start: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!started |-> (SRAM_we_n && !m1_end))
		else begin
			other_errors++;
			$display("Write strobe or m1_end active before m1_start");
		end

	write_in_region: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!SRAM_we_n |-> (int'(SRAM_address) >= int'(`M1_RGB_OFFSET))
			&& (int'(SRAM_address) < int'(`M1_RGB_OFFSET) + `M1_TOTAL_WRITES))
		else begin
			other_errors++;
			$display("Write landed outside the RGB region");
		end

	write_in_order: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!SRAM_we_n |-> int'(SRAM_address) == int'(`M1_RGB_OFFSET) + write_count)
		else begin
			value_errors++;
			$display("MISMATCH SRAM_address: expected %h, got %h",
				int'(`M1_RGB_OFFSET) + $sampled(write_count), $sampled(SRAM_address));
		end

	no_extra_writes: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!SRAM_we_n |-> write_count < `M1_TOTAL_WRITES)
		else begin
			other_errors++;
			$display("More writes than pixels in the picture");
		end

	even_pixel_ok: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!SRAM_we_n |->
			((SRAM_write_data ^ expected_word(write_count)) & even_mask(write_count)) == 16'h0)
		else begin
			value_errors++;
			$display("MISMATCH SRAM_write_data even pixel at %h: expected %h, got %h",
				$sampled(SRAM_address), expected_word($sampled(write_count)),
				$sampled(SRAM_write_data));
		end

	odd_pixel_ok: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!SRAM_we_n |->
			((SRAM_write_data ^ expected_word(write_count)) & ~even_mask(write_count)) == 16'h0)
		else begin
			value_errors++;
			$display("MISMATCH SRAM_write_data odd pixel at %h: expected %h, got %h",
				$sampled(SRAM_address), expected_word($sampled(write_count)),
				$sampled(SRAM_write_data));
		end

	end_after_last_write: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		$rose(m1_end) |-> $past(!SRAM_we_n)
			&& int'($past(SRAM_address)) == int'(`M1_RGB_OFFSET) + `M1_TOTAL_WRITES - 1)
		else begin
			other_errors++;
			$display("m1_end rose without the final write one cycle before");
		end

	end_holds: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		m1_end |=> m1_end)
		else begin
			other_errors++;
			$display("m1_end dropped before a new start");
		end

	quiet_after_end: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		m1_end |-> SRAM_we_n)
		else begin
			other_errors++;
			$display("Write issued after m1_end");
		end

	initial begin
		int cycles;
		resetn = 1'b0;
		m1_start = 1'b0;
		started = 1'b0;
		seed = 58557;
		load_image();
		repeat (2) @(posedge CLOCK_50_I);
		#1 resetn = 1'b1;
		@(posedge CLOCK_50_I);
		#1;
		m1_start = 1'b1;
		started = 1'b1;
		@(posedge CLOCK_50_I);
		#1 m1_start = 1'b0;
		cycles = 0;
		while (!m1_end && cycles < TIMEOUT_CYCLES) begin
			@(posedge CLOCK_50_I);
			cycles++;
		end
		if (!m1_end) begin
			other_errors++;
			$display("Timed out waiting for m1_end after %0d cycles", cycles);
		end else begin
			repeat (20) @(posedge CLOCK_50_I);  // Watch for stray writes
			assert (write_count == `M1_TOTAL_WRITES)
			else begin
				value_errors++;
				$display("MISMATCH write count: expected %h, got %h",
					`M1_TOTAL_WRITES, write_count);
			end
			assert (sat_high > 0 && sat_low > 0)
			else begin
				other_errors++;
				$display("Row 0 produced no clipped samples at both 255 and 0");
			end
		end
		$display("Errors: %0d mismatches, %0d other failures, %0d writes seen",
			value_errors, other_errors, write_count);
		if (value_errors == 0 && other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
